// ==== design/obi_integrity_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Checksum widths and the integrity types shared by the adapter blocks
// Compile before obi_bus_pkg, which takes its checksum widths from here
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package obi_integrity_pkg;

  // Request checksum over address, attributes and write data
  localparam int unsigned ACHK_W = 12;

  // Response checksum over read data and err
  localparam int unsigned RCHK_W = 5;

  // One granted transaction, kept until its response returns
  typedef struct packed {
    logic integrity;   // Region has integrity, enables rchk on the response
    logic we;          // Write transfer
    logic gntpar_err;  // Grant parity fault seen in the grant cycle
  } txn_entry_t;

  // Secure control from the CSR side
  typedef struct packed {
    logic integrity_en;  // Enables rchk checking
    logic reserved;
  } xsecure_ctrl_t;

  // Fault sources merged into the integrity error
  typedef struct packed {
    logic gntpar_err;     // gnt equal to gntpar
    logic rvalidpar_err;  // rvalid equal to rvalidpar
    logic rchk_err;       // Response checksum mismatch
  } integrity_err_t;

endpackage

`default_nettype wire

// ==== design/obi_bus_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// OBI A and R channel payloads, 32-bit data side only, no atomics
// Checksum field widths come from obi_integrity_pkg
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package obi_bus_pkg;

  localparam int unsigned ADDR_W    = 32;
  localparam int unsigned DATA_W    = 32;
  localparam int unsigned BE_W      = DATA_W / 8;
  localparam int unsigned PROT_W    = 3;
  localparam int unsigned MEMTYPE_W = 2;

  ////////////////////////////////////////////////////////////////////////////
  // A channel
  ////////////////////////////////////////////////////////////////////////////

  // Transaction request; achk is left zero by the LSU
  typedef struct packed {
    logic [ADDR_W-1:0]                    addr;
    logic                                 we;
    logic [BE_W-1:0]                      be;
    logic [DATA_W-1:0]                    wdata;
    logic [PROT_W-1:0]                    prot;
    logic [MEMTYPE_W-1:0]                 memtype;
    logic                                 dbg;
    logic                                 integrity;  // Region has integrity
    logic [obi_integrity_pkg::ACHK_W-1:0] achk;
  } obi_req_t;

  // Grant with its inverted parity
  typedef struct packed {
    logic gnt;
    logic gntpar;
  } obi_gnt_t;

  ////////////////////////////////////////////////////////////////////////////
  // R channel
  ////////////////////////////////////////////////////////////////////////////

  // Response; integrity and integrity_err are set by the adapter
  typedef struct packed {
    logic [DATA_W-1:0]                    rdata;
    logic                                 err;
    logic [obi_integrity_pkg::RCHK_W-1:0] rchk;
    logic                                 integrity;
    logic                                 integrity_err;
  } obi_resp_t;

  // Single-cycle response strobe, no back-pressure
  typedef struct packed {
    logic rvalid;
    logic rvalidpar;
  } obi_rvalid_t;

endpackage

`default_nettype wire

// ==== design/obi_achk_gen.sv ====
////////////////////////////////////////////////////////////////////////////
// Request checksum, atop is taken as zero since atomics are not supported
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module obi_achk_gen (
  input  obi_bus_pkg::obi_req_t                req_i,
  output logic [obi_integrity_pkg::ACHK_W-1:0] achk_o
);

  // No atomics, so the atop field is all zeros
  localparam logic [5:0] ATOP_ZERO = 6'b0;

  // Byte parities of wdata and addr, even sense
  logic [3:0] wdata_par;
  logic [3:0] addr_par;

  // Attribute parities, odd sense
  logic       dbg_par;
  logic       be_we_par;
  logic       prot_mt_par;

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      wdata_par[i] = ^req_i.wdata[8*i +: 8];
      addr_par[i]  = ^req_i.addr[8*i +: 8];
    end
  end

  assign dbg_par     = ~^req_i.dbg;
  assign be_we_par   = ~^{req_i.be, req_i.we};
  assign prot_mt_par = ~^{req_i.prot, req_i.memtype};

  // Bit order: wdata bytes 3..0, atop, dbg, be/we, prot/memtype, addr bytes 3..0
  assign achk_o = {wdata_par, ^ATOP_ZERO, dbg_par, be_we_par, prot_mt_par, addr_par};

endmodule

`default_nettype wire

// ==== design/obi_rchk_check.sv ====
////////////////////////////////////////////////////////////////////////////
// Response checksum check, purely combinational, mismatch only while enabled
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module obi_rchk_check (
  input  obi_bus_pkg::obi_resp_t resp_i,
  // rvalid AND head integrity AND integrity_en, formed by the top
  input  logic                   check_en_i,
  output logic                   rchk_err_o
);

  // Expected checksum rebuilt from the received payload
  logic [obi_integrity_pkg::RCHK_W-1:0] rchk_calc;
  logic [3:0]                           rdata_par;
  logic                                 err_par;
  logic                                 rchk_diff;

  ////////////////////////////////////////////////////////////////////////////
  // Recompute
  ////////////////////////////////////////////////////////////////////////////

  // One even parity bit per rdata byte
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      rdata_par[i] = ^resp_i.rdata[8*i +: 8];
    end
  end

  // err is covered with odd parity
  assign err_par = ~^resp_i.err;

  // Bytes 3..0 in bits 4..1, err in bit 0
  assign rchk_calc = {rdata_par, err_par};

  ////////////////////////////////////////////////////////////////////////////
  // Compare
  ////////////////////////////////////////////////////////////////////////////

  assign rchk_diff = (rchk_calc != resp_i.rchk);

  // Mismatch ignored for regions without integrity or when disabled
  assign rchk_err_o = check_en_i && rchk_diff;

endmodule

`default_nettype wire

// ==== design/obi_txn_store.sv ====
////////////////////////////////////////////////////////////////////////////
// In-order store of per-transaction attributes, one push per grant
// Caller must never push while full; responses must arrive in order
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module obi_txn_store #(
  parameter int unsigned MAX_OUTSTANDING = 2
) (
  input  logic                          clk,
  input  logic                          rst_n_i,
  // Written on a granted transfer
  input  logic                          push_i,
  input  obi_integrity_pkg::txn_entry_t push_entry_i,
  // Oldest entry retired on rvalid
  input  logic                          pop_i,
  output obi_integrity_pkg::txn_entry_t head_o,
  output logic                          full_o
);

  localparam int unsigned CNT_W = $clog2(MAX_OUTSTANDING + 1);
  localparam int unsigned PTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;

  // Pointer wrap point and full level
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(MAX_OUTSTANDING - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(MAX_OUTSTANDING);

  // Legal depth range
  if (MAX_OUTSTANDING < 1 || MAX_OUTSTANDING > 8) begin : g_depth_check
    $error("obi_txn_store: MAX_OUTSTANDING must be 1 to 8");
  end

  obi_integrity_pkg::txn_entry_t mem_q [MAX_OUTSTANDING];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             empty;

  ////////////////////////////////////////////////////////////////////////////
  // Entry storage
  ////////////////////////////////////////////////////////////////////////////

  // Payload only, no reset on the entries
  always_ff @(posedge clk) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_entry_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pointers and count
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + PTR_W'(1);
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + PTR_W'(1);
      end
      // Push and pop together leave the count as is
      case ({push_i, pop_i})
        2'b10:   cnt_q <= cnt_q + CNT_W'(1);
        2'b01:   cnt_q <= cnt_q - CNT_W'(1);
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  assign empty  = (cnt_q == '0);
  assign full_o = (cnt_q == FULL_CNT);

  // Oldest outstanding transaction
  assign head_o = mem_q[rd_ptr_q];

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  // Request gating upstream must keep grants away from a full store
  a_no_push_full : assert property (
    @(posedge clk) disable iff (!rst_n_i) push_i |-> !full_o
  ) else $error("obi_txn_store: push while full");

  // Bus returned rvalid with no transaction outstanding
  a_no_pop_empty : assert property (
    @(posedge clk) disable iff (!rst_n_i) pop_i |-> !empty
  ) else $error("obi_txn_store: response valid while store empty");

endmodule

`default_nettype wire

// ==== design/obi_data_ctrl.sv ====
////////////////////////////////////////////////////////////////////////////
// Request/grant gating and response assembly, all combinational
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module obi_data_ctrl (
  // LSU request side
  input  logic                                 trans_valid_i,
  input  obi_bus_pkg::obi_req_t                trans_i,
  output logic                                 trans_ready_o,
  // Datapath helpers
  input  logic [obi_integrity_pkg::ACHK_W-1:0] achk_i,
  input  logic                                 store_full_i,
  input  obi_integrity_pkg::txn_entry_t        head_i,
  input  logic                                 rchk_err_i,
  // OBI bus
  input  obi_bus_pkg::obi_gnt_t                obi_gnt_i,
  input  obi_bus_pkg::obi_rvalid_t             obi_rvalid_i,
  input  obi_bus_pkg::obi_resp_t               obi_resp_i,
  output logic                                 obi_req_o,
  output logic                                 obi_reqpar_o,
  output obi_bus_pkg::obi_req_t                obi_payload_o,
  // Store control
  output logic                                 push_o,
  output obi_integrity_pkg::txn_entry_t        push_entry_o,
  output logic                                 pop_o,
  // LSU response side, consumer always ready
  output logic                                 resp_valid_o,
  output obi_bus_pkg::obi_resp_t               resp_o,
  output logic                                 integrity_err_o
);

  obi_integrity_pkg::integrity_err_t faults;

  ////////////////////////////////////////////////////////////////////////////
  // A channel
  ////////////////////////////////////////////////////////////////////////////

  // No new request once the outstanding limit is reached
  assign obi_req_o     = trans_valid_i && !store_full_i;
  assign obi_reqpar_o  = !obi_req_o;
  assign trans_ready_o = obi_gnt_i.gnt && !store_full_i;

  // Payload passes straight through apart from the checksum
  always_comb begin
    obi_payload_o      = trans_i;
    obi_payload_o.achk = achk_i;
  end

  // Transfer on req and gnt together
  assign push_o = obi_req_o && obi_gnt_i.gnt;

  always_comb begin
    push_entry_o            = '0;
    push_entry_o.integrity  = trans_i.integrity;
    push_entry_o.we         = trans_i.we;
    push_entry_o.gntpar_err = faults.gntpar_err;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Parity faults
  ////////////////////////////////////////////////////////////////////////////

  // Parity lines carry the inverse, so equal values are a fault
  assign faults.gntpar_err    = (obi_gnt_i.gnt == obi_gnt_i.gntpar);
  assign faults.rvalidpar_err = (obi_rvalid_i.rvalid == obi_rvalid_i.rvalidpar);
  assign faults.rchk_err      = rchk_err_i;

  // Immediate alert, grant fault not delayed to its response
  assign integrity_err_o = |faults;

  ////////////////////////////////////////////////////////////////////////////
  // R channel
  ////////////////////////////////////////////////////////////////////////////

  assign resp_valid_o = obi_rvalid_i.rvalid;
  assign pop_o        = obi_rvalid_i.rvalid;

  // Stored grant fault travels with its own response
  always_comb begin
    resp_o               = obi_resp_i;
    resp_o.integrity     = head_i.integrity;
    resp_o.integrity_err = faults.rvalidpar_err || head_i.gntpar_err || faults.rchk_err;
  end

endmodule

`default_nettype wire

// ==== design/obi_data_sec_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Data-side OBI adapter with integrity, no atomics and no misaligned split
// Outstanding transfers limited to MAX_OUTSTANDING, 1 to 8
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module obi_data_sec_top #(
  parameter int unsigned MAX_OUTSTANDING = 2
) (
  input  logic                            clk,
  input  logic                            rst_n_i,
  // LSU transaction interface
  input  logic                            trans_valid_i,
  input  obi_bus_pkg::obi_req_t           trans_i,
  output logic                            trans_ready_o,
  output logic                            resp_valid_o,
  output obi_bus_pkg::obi_resp_t          resp_o,
  output logic                            integrity_err_o,
  input  obi_integrity_pkg::xsecure_ctrl_t xsecure_ctrl_i,
  // OBI master
  output logic                            obi_req_o,
  output logic                            obi_reqpar_o,
  output obi_bus_pkg::obi_req_t           obi_payload_o,
  input  obi_bus_pkg::obi_gnt_t           obi_gnt_i,
  input  obi_bus_pkg::obi_rvalid_t        obi_rvalid_i,
  input  obi_bus_pkg::obi_resp_t          obi_resp_i
);

  logic [obi_integrity_pkg::ACHK_W-1:0] achk;
  logic                                 store_full;
  obi_integrity_pkg::txn_entry_t        head;
  obi_integrity_pkg::txn_entry_t        push_entry;
  logic                                 push;
  logic                                 pop;
  logic                                 rchk_en;
  logic                                 rchk_err;

  // rchk counts only for integrity regions with checking enabled
  assign rchk_en = obi_rvalid_i.rvalid && head.integrity && xsecure_ctrl_i.integrity_en;

  obi_data_ctrl u_ctrl (
    .trans_valid_i   (trans_valid_i),
    .trans_i         (trans_i),
    .trans_ready_o   (trans_ready_o),
    .achk_i          (achk),
    .store_full_i    (store_full),
    .head_i          (head),
    .rchk_err_i      (rchk_err),
    .obi_gnt_i       (obi_gnt_i),
    .obi_rvalid_i    (obi_rvalid_i),
    .obi_resp_i      (obi_resp_i),
    .obi_req_o       (obi_req_o),
    .obi_reqpar_o    (obi_reqpar_o),
    .obi_payload_o   (obi_payload_o),
    .push_o          (push),
    .push_entry_o    (push_entry),
    .pop_o           (pop),
    .resp_valid_o    (resp_valid_o),
    .resp_o          (resp_o),
    .integrity_err_o (integrity_err_o)
  );

  obi_achk_gen u_achk (
    .req_i  (trans_i),
    .achk_o (achk)
  );

  obi_txn_store #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_store (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .push_i       (push),
    .push_entry_i (push_entry),
    .pop_i        (pop),
    .head_o       (head),
    .full_o       (store_full)
  );

  obi_rchk_check u_rchk (
    .resp_i     (obi_resp_i),
    .check_en_i (rchk_en),
    .rchk_err_o (rchk_err)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_obi_mem_model.sv ====
////////////////////////////////////////////////////////////////////////////
// OBI memory responder, random grant stalls, in-order responses
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_obi_mem_model (
  input  logic                     clk,
  input  logic                     rst_n_i,
  input  logic                     req_i,
  // Holds back all responses while high
  input  logic                     hold_i,
  // Fault controls for the transaction on the bus now
  input  logic                     gnt_bad_i,
  input  logic                     rvpar_bad_i,
  // Response payload captured at the grant
  input  obi_bus_pkg::obi_resp_t   resp_data_i,
  output obi_bus_pkg::obi_gnt_t    gnt_o,
  output obi_bus_pkg::obi_rvalid_t rvalid_o,
  output obi_bus_pkg::obi_resp_t   resp_o
);

  integer                 seed = 85469;
  logic                   gnt_q = 1'b0;
  logic                   rv_q = 1'b0;
  logic                   rv_bad_q = 1'b0;
  int unsigned            delay = 1;
  obi_bus_pkg::obi_resp_t rsp_q = '0;

  // Responses waiting, oldest first
  obi_bus_pkg::obi_resp_t resp_pend_q[$];
  logic                   bad_pend_q[$];

  // Capture on the transfer cycle
  always @(posedge clk) begin
    if (rst_n_i && req_i && gnt_q) begin
      resp_pend_q.push_back(resp_data_i);
      bad_pend_q.push_back(rvpar_bad_i);
    end
  end

  // Grant about 3 cycles in 4, response after 1 to 3 cycles
  always @(negedge clk) begin
    gnt_q    = (($random(seed) & 3) != 0);
    rv_q     = 1'b0;
    rv_bad_q = 1'b0;
    if (rst_n_i && !hold_i && resp_pend_q.size() != 0) begin
      if (delay == 0) begin
        rv_q     = 1'b1;
        rsp_q    = resp_pend_q.pop_front();
        rv_bad_q = bad_pend_q.pop_front();
        delay    = 1 + ($unsigned($random(seed)) % 3);
      end else begin
        delay = delay - 1;
      end
    end
  end

  // Parity lines carry the inverse unless a fault is injected
  assign gnt_o.gnt          = gnt_q;
  assign gnt_o.gntpar       = gnt_q ? gnt_bad_i : 1'b1;
  assign rvalid_o.rvalid    = rv_q;
  assign rvalid_o.rvalidpar = rv_bad_q ? rv_q : !rv_q;
  assign resp_o             = rsp_q;

endmodule

`default_nettype wire

// ==== testbench/tb_obi_data_sec.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the data-side OBI adapter, MAX_OUTSTANDING of 2
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_obi_data_sec;

  localparam int NUM_ROWS = 10;
  // Table rows plus three in the outstanding-limit phase
  localparam int TOTAL    = NUM_ROWS + 3;
  localparam int WD_CYC   = TOTAL * 20 + 16;
  localparam int MAX_OUT  = 2;

  localparam logic [1:0] F_NONE   = 2'd0;
  localparam logic [1:0] F_GNTPAR = 2'd1;
  localparam logic [1:0] F_RVPAR  = 2'd2;
  localparam logic [1:0] F_RCHK   = 2'd3;

  typedef struct packed {
    logic [31:0] addr;
    logic        we;
    logic [31:0] wdata;
    logic [3:0]  be;
    logic [2:0]  prot;
    logic [1:0]  memtype;
    logic        dbg;
    logic        integrity;
    logic        integrity_en;
    logic [1:0]  fault;
    logic [31:0] rdata;
  } row_t;

  logic                             clk;
  logic                             rst_n;
  logic                             trans_valid;
  obi_bus_pkg::obi_req_t            trans;
  obi_integrity_pkg::xsecure_ctrl_t xsecure;
  logic                             trans_ready;
  logic                             resp_valid;
  obi_bus_pkg::obi_resp_t           resp;
  logic                             integrity_err;
  logic                             obi_req;
  logic                             obi_reqpar;
  obi_bus_pkg::obi_req_t            obi_payload;
  obi_bus_pkg::obi_gnt_t            obi_gnt;
  obi_bus_pkg::obi_rvalid_t         obi_rvalid;
  obi_bus_pkg::obi_resp_t           obi_resp;
  logic                             hold;
  logic                             gnt_bad;
  logic                             rvpar_bad;
  obi_bus_pkg::obi_resp_t           mem_data;

  row_t table_q [NUM_ROWS];
  int   cur_row;
  int   grant_cnt;
  int   resp_cnt;
  // Expected store contents, row index and grant fault
  int   exp_row_q[$];
  logic exp_gf_q[$];

  obi_data_sec_top #(
    .MAX_OUTSTANDING (MAX_OUT)
  ) u_dut (
    .clk             (clk),
    .rst_n_i         (rst_n),
    .trans_valid_i   (trans_valid),
    .trans_i         (trans),
    .trans_ready_o   (trans_ready),
    .resp_valid_o    (resp_valid),
    .resp_o          (resp),
    .integrity_err_o (integrity_err),
    .xsecure_ctrl_i  (xsecure),
    .obi_req_o       (obi_req),
    .obi_reqpar_o    (obi_reqpar),
    .obi_payload_o   (obi_payload),
    .obi_gnt_i       (obi_gnt),
    .obi_rvalid_i    (obi_rvalid),
    .obi_resp_i      (obi_resp)
  );

  tb_obi_mem_model u_mem (
    .clk         (clk),
    .rst_n_i     (rst_n),
    .req_i       (obi_req),
    .hold_i      (hold),
    .gnt_bad_i   (gnt_bad),
    .rvpar_bad_i (rvpar_bad),
    .resp_data_i (mem_data),
    .gnt_o       (obi_gnt),
    .rvalid_o    (obi_rvalid),
    .resp_o      (obi_resp)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference checksums
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [11:0] achk_ref(input obi_bus_pkg::obi_req_t r);
    return {^r.wdata[31:24], ^r.wdata[23:16], ^r.wdata[15:8], ^r.wdata[7:0],
            1'b0, ~^r.dbg, ~^{r.be, r.we}, ~^{r.prot, r.memtype},
            ^r.addr[31:24], ^r.addr[23:16], ^r.addr[15:8], ^r.addr[7:0]};
  endfunction

  function automatic logic [4:0] rchk_ref(input logic [31:0] d, input logic e);
    return {^d[31:24], ^d[23:16], ^d[15:8], ^d[7:0], ~^e};
  endfunction

  // Response the model returns for a row, err taken from rdata bit 31
  function automatic obi_bus_pkg::obi_resp_t row_resp(input row_t r);
    obi_bus_pkg::obi_resp_t s;
    s       = '0;
    s.rdata = r.rdata;
    s.err   = r.rdata[31];
    s.rchk  = rchk_ref(r.rdata, r.rdata[31]) ^ {4'b0, r.fault == F_RCHK};
    return s;
  endfunction

  function automatic obi_bus_pkg::obi_req_t row_req(input row_t r);
    obi_bus_pkg::obi_req_t q;
    q           = '0;
    q.addr      = r.addr;
    q.we        = r.we;
    q.be        = r.be;
    q.wdata     = r.wdata;
    q.prot      = r.prot;
    q.memtype   = r.memtype;
    q.dbg       = r.dbg;
    q.integrity = r.integrity;
    return q;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_on_mismatch(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_achk(input logic [11:0] got, input logic [11:0] exp);
    if (got !== exp) begin
      stop_on_mismatch($sformatf("achk got %h expected %h", got, exp));
    end
  endtask

  task automatic check_req(input obi_bus_pkg::obi_req_t got,
                           input obi_bus_pkg::obi_req_t exp);
    if (got !== exp) begin
      stop_on_mismatch($sformatf("payload got %h expected %h", got, exp));
    end
  endtask

  task automatic check_resp(input obi_bus_pkg::obi_resp_t got,
                            input obi_bus_pkg::obi_resp_t exp);
    if (got !== exp) begin
      stop_on_mismatch($sformatf("response got %h expected %h", got, exp));
    end
  endtask

  task automatic check_err(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_on_mismatch($sformatf("%s got %b expected %b", what, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Monitor, sampled on the rising edge
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    obi_bus_pkg::obi_resp_t exp_r;
    obi_bus_pkg::obi_req_t  exp_q;
    logic                   rv_fault;
    logic                   rchk_bad;
    logic                   gnt_fault;
    logic                   gf_exp;
    logic                   room;
    row_t                   r;
    if (rst_n) begin
      // Request and ready are gated once MAX_OUT transfers are outstanding
      room = (exp_row_q.size() < MAX_OUT);
      check_err(obi_req, trans_valid && room, "obi_req");
      check_err(trans_ready, obi_gnt.gnt && room, "trans_ready");
      check_err(obi_reqpar, !obi_req, "reqpar");
      check_err(resp_valid, obi_rvalid.rvalid, "resp_valid");
      // Faults injected by the stimulus in this cycle
      gnt_fault = obi_gnt.gnt && gnt_bad;
      rv_fault  = 1'b0;
      rchk_bad  = 1'b0;
      if (obi_rvalid.rvalid) begin
        if (exp_row_q.size() == 0) begin
          $display("Response returned with no transaction outstanding at %0t ns", $time);
          $display("Simulation FAILED");
          $fatal(1);
        end
        r        = table_q[exp_row_q.pop_front()];
        gf_exp   = exp_gf_q.pop_front();
        rv_fault = (r.fault == F_RVPAR);
        rchk_bad = r.integrity && r.integrity_en && (r.fault == F_RCHK);
        exp_r               = row_resp(r);
        exp_r.integrity     = r.integrity;
        exp_r.integrity_err = rv_fault || gf_exp || rchk_bad;
        check_resp(resp, exp_r);
        resp_cnt++;
      end
      // Immediate flag covers all three sources in this cycle
      check_err(integrity_err, gnt_fault || rv_fault || rchk_bad, "integrity_err");
      if (obi_req && obi_gnt.gnt) begin
        exp_q      = row_req(table_q[cur_row]);
        exp_q.achk = achk_ref(exp_q);
        check_achk(obi_payload.achk, exp_q.achk);
        check_req(obi_payload, exp_q);
        exp_row_q.push_back(cur_row);
        exp_gf_q.push_back(gnt_fault);
        grant_cnt++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // Secure control follows the oldest outstanding row
  // Each response then sees the enable of its own row
  initial begin
    xsecure = '0;
    forever begin
      @(negedge clk);
      if (exp_row_q.size() != 0) begin
        xsecure.integrity_en = table_q[exp_row_q[0]].integrity_en;
      end
    end
  end

  // Drives a row on the falling edge and holds it
  task automatic drive_row(input int idx);
    @(negedge clk);
    cur_row     = idx;
    trans_valid = 1'b1;
    trans       = row_req(table_q[idx]);
    gnt_bad     = (table_q[idx].fault == F_GNTPAR);
    rvpar_bad   = (table_q[idx].fault == F_RVPAR);
    mem_data    = row_resp(table_q[idx]);
  endtask

  task automatic apply_row(input int idx);
    drive_row(idx);
    @(posedge clk);
    while (!trans_ready) @(posedge clk);
  endtask

  task automatic go_idle();
    @(negedge clk);
    trans_valid = 1'b0;
    gnt_bad     = 1'b0;
    rvpar_bad   = 1'b0;
  endtask

  task automatic drain();
    while (exp_row_q.size() != 0) @(posedge clk);
  endtask

  initial begin
    // addr, we, wdata, be, prot, memtype, dbg, integrity, integrity_en, fault, rdata
    table_q[0] = '{32'h0000_1000, 1'b0, 32'h0, 4'hF, 3'b111, 2'b00, 1'b0, 1'b1, 1'b1,
                   F_NONE, 32'h1234_5678};
    table_q[1] = '{32'h0000_2004, 1'b1, 32'hDEAD_BEEF, 4'h3, 3'b011, 2'b01, 1'b0, 1'b0,
                   1'b1, F_NONE, 32'h0000_0000};
    table_q[2] = '{32'h8000_0010, 1'b0, 32'h0, 4'hF, 3'b111, 2'b10, 1'b1, 1'b1, 1'b1,
                   F_GNTPAR, 32'hA5A5_0F0F};
    table_q[3] = '{32'h0001_0020, 1'b0, 32'h0, 4'hC, 3'b001, 2'b00, 1'b0, 1'b1, 1'b1,
                   F_RVPAR, 32'h0102_0304};
    table_q[4] = '{32'h0001_0024, 1'b0, 32'h0, 4'hF, 3'b111, 2'b11, 1'b0, 1'b1, 1'b1,
                   F_RCHK, 32'hFFFF_0001};
    table_q[5] = '{32'h0002_0000, 1'b0, 32'h0, 4'h1, 3'b110, 2'b00, 1'b0, 1'b0, 1'b1,
                   F_RCHK, 32'h7777_8888};
    table_q[6] = '{32'h0002_0040, 1'b0, 32'h0, 4'hF, 3'b111, 2'b01, 1'b0, 1'b1, 1'b0,
                   F_RCHK, 32'h8000_0000};
    table_q[7] = '{32'h0003_0000, 1'b1, 32'h0BAD_F00D, 4'hF, 3'b111, 2'b00, 1'b1, 1'b1,
                   1'b0, F_NONE, 32'h0000_00FF};
    table_q[8] = '{32'hFFFF_FFFC, 1'b0, 32'h0, 4'h8, 3'b100, 2'b10, 1'b0, 1'b0, 1'b0,
                   F_GNTPAR, 32'hC001_D00D};
    table_q[9] = '{32'h0004_0008, 1'b0, 32'h0, 4'hF, 3'b111, 2'b00, 1'b0, 1'b1, 1'b1,
                   F_NONE, 32'h5555_AAAA};
  end

  // Watchdog sized from the transaction count
  initial begin
    repeat (WD_CYC) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", WD_CYC);
    $display("Simulation FAILED");
    $fatal(1);
  end

  initial begin
    rst_n       = 1'b0;
    trans_valid = 1'b0;
    trans       = '0;
    hold        = 1'b0;
    gnt_bad     = 1'b0;
    rvpar_bad   = 1'b0;
    mem_data    = '0;
    cur_row     = 0;
    grant_cnt   = 0;
    resp_cnt    = 0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < NUM_ROWS; i++) begin
      apply_row(i);
    end
    go_idle();
    drain();

    // Outstanding limit, responses held back after two grants
    hold = 1'b1;
    apply_row(0);
    apply_row(9);
    drive_row(1);
    repeat (6) begin
      @(posedge clk);
      check_err(trans_ready, 1'b0, "trans_ready while full");
      check_err(obi_req, 1'b0, "obi_req while full");
    end
    @(negedge clk);
    hold = 1'b0;
    @(posedge clk);
    while (!trans_ready) @(posedge clk);
    go_idle();
    drain();
    repeat (4) @(posedge clk);

    if (grant_cnt == TOTAL && resp_cnt == TOTAL) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      $display("Transfer count %0d or response count %0d differs from %0d",
               grant_cnt, resp_cnt, TOTAL);
      $display("Simulation FAILED");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

// ==== obi_data_sec.f ====
design/obi_integrity_pkg.sv
design/obi_bus_pkg.sv
design/obi_achk_gen.sv
design/obi_rchk_check.sv
design/obi_txn_store.sv
design/obi_data_ctrl.sv
design/obi_data_sec_top.sv
testbench/tb_obi_mem_model.sv
testbench/tb_obi_data_sec.sv

// ==== Makefile ====
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= tb_obi_data_sec
FILELIST ?= obi_data_sec.f
LOG      ?= sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
